// ==== logic/axi_snoop_pkg.sv ====
`default_nettype none

package axi_snoop_pkg;

  // bus widths of the AXI4-Lite link being snooped
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int RESP_W = 2;

  // the stream side carries one 64-bit word per channel event
  localparam int STREAM_W = 64;
  localparam int STREAM_STRB_W = STREAM_W / 8;

  // width of the tag at the top of every stream word
  localparam int KIND_W = 3;

  // zero fill between the tag and the address in a header word
  localparam int HDR_PAD_W = STREAM_W - KIND_W - ADDR_W;

  // zero fill between the strobe and the data in a beat word
  localparam int BEAT_PAD_W = STREAM_W - KIND_W - RESP_W - 3 - STRB_W - DATA_W;

  // address channel payload, shared by AR and AW
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } ax_chan_t;

  // write data payload
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_chan_t;

  // read data payload with its response
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
  } r_chan_t;

  // write response payload
  typedef struct packed {
    logic [RESP_W-1:0] resp;
  } b_chan_t;

  // tag naming the AXI channel that produced a stream word
  // the encoding matches the channel order used by the capture side
  typedef enum logic [KIND_W-1:0] {
    NONE = 3'd0,
    AR   = 3'd1,
    R    = 3'd2,
    AW   = 3'd3,
    W    = 3'd4,
    B    = 3'd5
  } stream_kind_e;

  // header view used for AR and AW events
  // the address sits in the low 32 bits so a sink can read it without shifting
  typedef struct packed {
    stream_kind_e         kind;
    logic [HDR_PAD_W-1:0] zero;
    logic [ADDR_W-1:0]    addr;
  } stream_hdr_t;

  // beat view used for R, W and B events
  // resp and strb live in the upper bytes, data in the low 32 bits
  typedef struct packed {
    stream_kind_e          kind;
    logic [RESP_W-1:0]     resp;
    logic [2:0]            zero_hi;
    logic [STRB_W-1:0]     strb;
    logic [BEAT_PAD_W-1:0] zero_lo;
    logic [DATA_W-1:0]     data;
  } stream_beat_t;

  // one stream word, read either as a header or as a beat
  // the kind field lands on the same bits in both views, so a sink
  // decodes the tag first and then picks the view
  typedef union packed {
    stream_hdr_t  hdr;
    stream_beat_t beat;
  } stream_word_u;

endpackage

`default_nettype wire

// ==== logic/axi_snoop_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_snoop_top (
  input  wire                              clk,
  input  wire                              resetn,
  // upstream side, facing the AXI4-Lite master
  input  wire axi_snoop_pkg::ax_chan_t     snoop_ar,
  input  wire axi_snoop_pkg::ax_chan_t     snoop_aw,
  input  wire axi_snoop_pkg::w_chan_t      snoop_w,
  output axi_snoop_pkg::r_chan_t           snoop_r,
  output axi_snoop_pkg::b_chan_t           snoop_b,
  input  wire                              snoop_arvalid,
  input  wire                              snoop_awvalid,
  input  wire                              snoop_wvalid,
  input  wire                              snoop_rready,
  input  wire                              snoop_bready,
  output logic                             snoop_arready,
  output logic                             snoop_awready,
  output logic                             snoop_wready,
  output logic                             snoop_rvalid,
  output logic                             snoop_bvalid,
  // downstream side, facing the AXI4-Lite slave
  output axi_snoop_pkg::ax_chan_t          fwd_ar,
  output axi_snoop_pkg::ax_chan_t          fwd_aw,
  output axi_snoop_pkg::w_chan_t           fwd_w,
  input  wire axi_snoop_pkg::r_chan_t      fwd_r,
  input  wire axi_snoop_pkg::b_chan_t      fwd_b,
  output logic                             fwd_arvalid,
  output logic                             fwd_awvalid,
  output logic                             fwd_wvalid,
  output logic                             fwd_rready,
  output logic                             fwd_bready,
  input  wire                              fwd_arready,
  input  wire                              fwd_awready,
  input  wire                              fwd_wready,
  input  wire                              fwd_rvalid,
  input  wire                              fwd_bvalid,
  // AXI-Stream copy of every channel event
  output axi_snoop_pkg::stream_word_u      stream_tdata,
  output logic [axi_snoop_pkg::STREAM_STRB_W-1:0] stream_tstrb,
  output logic                             stream_tlast,
  output logic                             stream_tvalid,
  input  wire                              stream_tready
);
  import axi_snoop_pkg::*;

  // handshake between the sequencer and the packer
  logic         slot_free;
  logic         capture;
  stream_kind_e capture_kind;

  // payloads cross the snooper without any register stage
  // only the valid and ready wires are gated by the sequencer
  assign fwd_ar  = snoop_ar;
  assign fwd_aw  = snoop_aw;
  assign fwd_w   = snoop_w;
  assign snoop_r = fwd_r;
  assign snoop_b = fwd_b;

  // port names of the sequencer match the top level one to one
  snoop_sequencer sequencer_i (.*);

  // the packer sees the same payload that is handshaking on the bus
  stream_packer packer_i (
    .clk           (clk),
    .resetn        (resetn),
    .capture       (capture),
    .capture_kind  (capture_kind),
    .ar            (snoop_ar),
    .aw            (snoop_aw),
    .w             (snoop_w),
    .r             (fwd_r),
    .b             (fwd_b),
    .stream_tready (stream_tready),
    .stream_tdata  (stream_tdata),
    .stream_tstrb  (stream_tstrb),
    .stream_tlast  (stream_tlast),
    .stream_tvalid (stream_tvalid),
    .slot_free     (slot_free)
  );

endmodule

`default_nettype wire

// ==== logic/snoop_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module snoop_sequencer (
  input  wire                         clk,
  input  wire                         resetn,
  // raw valid and ready from both AXI sides
  input  wire                         snoop_arvalid,
  input  wire                         snoop_awvalid,
  input  wire                         snoop_wvalid,
  input  wire                         snoop_rready,
  input  wire                         snoop_bready,
  input  wire                         fwd_arready,
  input  wire                         fwd_awready,
  input  wire                         fwd_wready,
  input  wire                         fwd_rvalid,
  input  wire                         fwd_bvalid,
  // gated valid and ready towards both AXI sides
  output logic                        fwd_arvalid,
  output logic                        fwd_awvalid,
  output logic                        fwd_wvalid,
  output logic                        fwd_rready,
  output logic                        fwd_bready,
  output logic                        snoop_arready,
  output logic                        snoop_awready,
  output logic                        snoop_wready,
  output logic                        snoop_rvalid,
  output logic                        snoop_bvalid,
  // stream packer handshake
  input  wire                         slot_free,
  output logic                        capture,
  output axi_snoop_pkg::stream_kind_e capture_kind
);
  import axi_snoop_pkg::*;

  // where the single outstanding transaction currently stands
  typedef enum logic [1:0] {
    IDLE,
    RD_DATA,
    WR_DATA,
    WR_RESP
  } seq_state_e;

  seq_state_e state;

  // set when the last address grant went to AR
  logic last_grant_ar;

  // one permit per channel, all of them blocked while the stream word is stuck
  logic permit_ar;
  logic permit_aw;
  logic permit_w;
  logic permit_r;
  logic permit_b;

  // completed handshakes, seen identically on both sides of the snooper
  logic ar_hs;
  logic aw_hs;
  logic w_hs;
  logic r_hs;
  logic b_hs;

  // in IDLE an address channel is allowed unless the other one is also
  // waiting and it is the other one's turn
  assign permit_ar = slot_free && (state == IDLE) && (!snoop_awvalid || !last_grant_ar);
  assign permit_aw = slot_free && (state == IDLE) && (!snoop_arvalid || last_grant_ar);
  assign permit_r  = slot_free && (state == RD_DATA);
  assign permit_w  = slot_free && (state == WR_DATA);
  assign permit_b  = slot_free && (state == WR_RESP);

  // valid follows its source, ready follows its sink, both only under a permit
  assign fwd_arvalid   = snoop_arvalid && permit_ar;
  assign snoop_arready = fwd_arready && permit_ar;
  assign fwd_awvalid   = snoop_awvalid && permit_aw;
  assign snoop_awready = fwd_awready && permit_aw;
  assign fwd_wvalid    = snoop_wvalid && permit_w;
  assign snoop_wready  = fwd_wready && permit_w;
  // response channels flow the other way
  assign snoop_rvalid  = fwd_rvalid && permit_r;
  assign fwd_rready    = snoop_rready && permit_r;
  assign snoop_bvalid  = fwd_bvalid && permit_b;
  assign fwd_bready    = snoop_bready && permit_b;

  assign ar_hs = fwd_arvalid && fwd_arready;
  assign aw_hs = fwd_awvalid && fwd_awready;
  assign w_hs  = fwd_wvalid && fwd_wready;
  assign r_hs  = fwd_rvalid && fwd_rready;
  assign b_hs  = fwd_bvalid && fwd_bready;

  // the permits are mutually exclusive, so at most one handshake per cycle
  always_comb begin
    capture      = ar_hs || aw_hs || w_hs || r_hs || b_hs;
    capture_kind = NONE;
    if (ar_hs) begin
      capture_kind = AR;
    end else if (aw_hs) begin
      capture_kind = AW;
    end else if (w_hs) begin
      capture_kind = W;
    end else if (r_hs) begin
      capture_kind = R;
    end else if (b_hs) begin
      capture_kind = B;
    end
  end

  // state moves on the handshake edge, a stalled channel just holds it
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= IDLE;
      // pretend AW won last so the first contested grant goes to AR
      last_grant_ar <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (ar_hs) begin
            state         <= RD_DATA;
            last_grant_ar <= 1'b1;
          end else if (aw_hs) begin
            state         <= WR_DATA;
            last_grant_ar <= 1'b0;
          end
        end
        RD_DATA: begin
          if (r_hs) begin
            state <= IDLE;
          end
        end
        WR_DATA: begin
          if (w_hs) begin
            state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_hs) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/stream_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

module stream_packer (
  input  wire                                     clk,
  input  wire                                     resetn,
  input  wire                                     capture,
  input  wire axi_snoop_pkg::stream_kind_e        capture_kind,
  // payloads of all five channels, only the captured one is used
  input  wire axi_snoop_pkg::ax_chan_t            ar,
  input  wire axi_snoop_pkg::ax_chan_t            aw,
  input  wire axi_snoop_pkg::w_chan_t             w,
  input  wire axi_snoop_pkg::r_chan_t             r,
  input  wire axi_snoop_pkg::b_chan_t             b,
  input  wire                                     stream_tready,
  output axi_snoop_pkg::stream_word_u             stream_tdata,
  output logic [axi_snoop_pkg::STREAM_STRB_W-1:0] stream_tstrb,
  output logic                                    stream_tlast,
  output logic                                    stream_tvalid,
  output logic                                    slot_free
);
  import axi_snoop_pkg::*;

  // next word, strobe and last flag, built from the captured channel
  stream_word_u             word_d;
  logic [STREAM_STRB_W-1:0] strb_d;
  logic                     last_d;

  always_comb begin
    word_d = '0;
    strb_d = '0;
    last_d = 1'b0;
    // the top byte holds the tag and is meaningful in every word
    strb_d[STREAM_STRB_W-1] = 1'b1;
    case (capture_kind)
      AR: begin
        word_d.hdr.kind       = AR;
        word_d.hdr.addr       = ar.addr;
        strb_d[STRB_W-1:0]    = '1;
      end
      AW: begin
        word_d.hdr.kind       = AW;
        word_d.hdr.addr       = aw.addr;
        strb_d[STRB_W-1:0]    = '1;
      end
      R: begin
        word_d.beat.kind      = R;
        word_d.beat.resp      = r.resp;
        word_d.beat.data      = r.data;
        strb_d[STRB_W-1:0]    = '1;
        // a read ends with its data beat
        last_d                = 1'b1;
      end
      W: begin
        word_d.beat.kind      = W;
        word_d.beat.strb      = w.strb;
        word_d.beat.data      = w.data;
        // byte 6 carries the copied write strobe
        strb_d[STREAM_STRB_W-2] = 1'b1;
        // only the bytes the master actually wrote are valid data
        strb_d[STRB_W-1:0]    = w.strb;
      end
      B: begin
        // resp sits in the tag byte, so no data byte is marked
        word_d.beat.kind      = B;
        word_d.beat.resp      = b.resp;
        last_d                = 1'b1;
      end
      default: begin
        word_d = '0;
      end
    endcase
  end

  // a new word may enter when the output is empty or is leaving this cycle
  assign slot_free = !stream_tvalid || stream_tready;

  // valid drops once the sink takes the word, unless a new one arrives
  always_ff @(posedge clk) begin
    if (!resetn) begin
      stream_tvalid <= 1'b0;
    end else if (capture) begin
      stream_tvalid <= 1'b1;
    end else if (stream_tready) begin
      stream_tvalid <= 1'b0;
    end
  end

  // the word itself only changes on capture, so it stays put under back-pressure
  always_ff @(posedge clk) begin
    if (capture) begin
      stream_tdata <= word_d;
      stream_tstrb <= strb_d;
      stream_tlast <= last_d;
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
logic/axi_snoop_pkg.sv
logic/snoop_sequencer.sv
logic/stream_packer.sv
logic/axi_snoop_top.sv
tests/axi_snoop_properties.sv
tests/tb_axi_snoop.sv

// ==== tests/axi_snoop_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_snoop_properties (
  input wire                               clk,
  input wire                               resetn,
  input wire                               snoop_arvalid,
  input wire                               snoop_arready,
  input wire                               snoop_awvalid,
  input wire                               snoop_awready,
  input wire                               snoop_wvalid,
  input wire                               snoop_wready,
  input wire                               snoop_rvalid,
  input wire                               snoop_rready,
  input wire                               snoop_bvalid,
  input wire                               snoop_bready,
  input wire                               fwd_arvalid,
  input wire                               fwd_awvalid,
  input wire                               fwd_wvalid,
  input wire                               fwd_rvalid,
  input wire                               fwd_bvalid,
  input wire axi_snoop_pkg::stream_word_u  stream_tdata,
  input wire                               stream_tvalid,
  input wire                               stream_tready
);
  import axi_snoop_pkg::*;

  logic stall;
  logic any_upstream_hs;

  // a stream word that is offered but not taken this cycle
  assign stall = stream_tvalid && !stream_tready;
  assign any_upstream_hs = (snoop_arvalid && snoop_arready) || (snoop_awvalid && snoop_awready) ||
                           (snoop_wvalid && snoop_wready) || (snoop_rvalid && snoop_rready) ||
                           (snoop_bvalid && snoop_bready);

  // the sink must see the same word until it accepts it
  stream_hold: assert property (@(posedge clk) disable iff (!resetn)
    stall |=> stream_tvalid && $stable(stream_tdata))
    else $error("stream word changed before it was accepted");

  // a stalled stream blocks every channel, otherwise a copy would be lost
  no_hs_in_stall: assert property (@(posedge clk) disable iff (!resetn)
    stall |-> !any_upstream_hs)
    else $error("upstream handshake while the stream was stalled");

  // the snooper never makes up a valid on either side
  fwd_valid_src: assert property (@(posedge clk) disable iff (!resetn)
    (fwd_arvalid |-> snoop_arvalid) and (fwd_awvalid |-> snoop_awvalid) and
    (fwd_wvalid |-> snoop_wvalid) and (snoop_rvalid |-> fwd_rvalid) and
    (snoop_bvalid |-> fwd_bvalid))
    else $error("gated valid without a source valid");

endmodule

`default_nettype wire

// ==== tests/tb_axi_snoop.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_axi_snoop;
  import axi_snoop_pkg::*;

  localparam int NUM_OPS = 200;
  localparam int TIMEOUT_CYCLES = 2000;

  // expected stream word, strobe and last flag
  typedef struct packed {
    logic [63:0] word;
    logic [7:0]  strb;
    logic        last;
  } exp_pkt_t;

  logic clk, resetn;
  ax_chan_t snoop_ar, snoop_aw, fwd_ar, fwd_aw;
  w_chan_t snoop_w, fwd_w;
  r_chan_t snoop_r, fwd_r;
  b_chan_t snoop_b, fwd_b;
  logic snoop_arvalid, snoop_awvalid, snoop_wvalid, snoop_rready, snoop_bready;
  logic snoop_arready, snoop_awready, snoop_wready, snoop_rvalid, snoop_bvalid;
  logic fwd_arvalid, fwd_awvalid, fwd_wvalid, fwd_rready, fwd_bready;
  logic fwd_arready, fwd_awready, fwd_wready, fwd_rvalid, fwd_bvalid;
  stream_word_u stream_tdata;
  logic [7:0] stream_tstrb;
  logic stream_tlast, stream_tvalid, stream_tready;

  exp_pkt_t exp_q[$];
  exp_pkt_t sink_pkt;
  logic [31:0] slave_mem [16];
  logic [31:0] model_mem [16];
  // the slave model samples its handshakes on the rising edge
  logic ar_fire, aw_fire, w_fire, r_fire, b_fire, rd_pending, aw_seen, w_seen;
  logic [3:0] rd_idx, wr_idx;
  ax_chan_t ar_q, aw_q;
  w_chan_t w_q;
  logic held_valid;
  logic [63:0] held_word;
  logic last_grant_ar;
  int op, idx, cycles;
  logic [31:0] wdata, exp_rd;
  logic [3:0] wstrb;

  axi_snoop_top dut_i (.*);

  bind axi_snoop_top axi_snoop_properties props_i (.*);

  always #10 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else abort_run($sformatf("FAIL %s expected %0h got %0h", name, exp, act));
  endtask

  // initial memory contents depend on every address bit
  function automatic logic [31:0] fill_word(input int i);
    return 32'h5a3c_96e1 ^ (i * 32'h0101_0407) ^ {i[3:0], 28'h0};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // the packet layout is written out bit by bit and resp is always OKAY
  function automatic void push_exp(input stream_kind_e kind, input logic [31:0] addr,
                                   input logic [31:0] data, input logic [3:0] strb);
    exp_pkt_t p;
    p.last = 1'b0;
    case (kind)
      AR, AW: begin
        p.word = {kind, 29'd0, addr};
        p.strb = 8'b1000_1111;
      end
      R: begin
        p.word = {kind, 2'b00, 3'b000, 4'h0, 20'd0, data};
        p.strb = 8'b1000_1111;
        p.last = 1'b1;
      end
      W: begin
        p.word = {kind, 2'b00, 3'b000, strb, 20'd0, data};
        p.strb = {2'b11, 2'b00, strb};
      end
      default: begin
        p.word = {kind, 2'b00, 59'd0};
        p.strb = 8'b1000_0000;
        p.last = 1'b1;
      end
    endcase
    exp_q.push_back(p);
  endfunction

  task automatic run_read(input int i, input logic [31:0] exp_data);
    int n;
    logic done;
    r_chan_t got;
    @(negedge clk);
    // the protection bits follow the word index so that requests differ in them too
    snoop_ar = '{addr: 32'(i * 4), prot: 3'(i)};
    snoop_arvalid = 1'b1;
    n = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = snoop_arready;
      if (done) check_value("forwarded ar", {32'(i * 4), 3'(i)}, fwd_ar);
      n++;
      assert (n < TIMEOUT_CYCLES) else abort_run("read address was never accepted");
    end
    @(negedge clk);
    snoop_arvalid = 1'b0;
    snoop_rready = 1'b1;
    n = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = snoop_rvalid;
      got = snoop_r;
      n++;
      assert (n < TIMEOUT_CYCLES) else abort_run("read data never came back");
    end
    @(negedge clk);
    snoop_rready = 1'b0;
    check_value("read data", exp_data, got.data);
    check_value("read resp", 0, got.resp);
  endtask

  task automatic run_write(input int i, input logic [31:0] data, input logic [3:0] strb);
    int n;
    logic aw_done, w_done, b_done;
    @(negedge clk);
    snoop_aw = '{addr: 32'(i * 4), prot: 3'(i)};
    snoop_w = '{data: data, strb: strb};
    snoop_awvalid = 1'b1;
    snoop_wvalid = 1'b1;
    n = 0;
    aw_done = 1'b0;
    w_done = 1'b0;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (snoop_awvalid && snoop_awready) begin
        aw_done = 1'b1;
        check_value("forwarded aw", {32'(i * 4), 3'(i)}, fwd_aw);
      end
      if (snoop_wvalid && snoop_wready) w_done = 1'b1;
      n++;
      assert (n < TIMEOUT_CYCLES) else abort_run("write address or data was never accepted");
      @(negedge clk);
      if (aw_done) snoop_awvalid = 1'b0;
      if (w_done) snoop_wvalid = 1'b0;
    end
    snoop_bready = 1'b1;
    n = 0;
    b_done = 1'b0;
    while (!b_done) begin
      @(posedge clk);
      b_done = snoop_bvalid;
      if (b_done) check_value("write resp", 0, snoop_b.resp);
      n++;
      assert (n < TIMEOUT_CYCLES) else abort_run("write response never came back");
    end
    @(negedge clk);
    snoop_bready = 1'b0;
  endtask

  always @(posedge clk) begin
    ar_fire <= fwd_arvalid && fwd_arready;
    aw_fire <= fwd_awvalid && fwd_awready;
    w_fire  <= fwd_wvalid && fwd_wready;
    r_fire  <= fwd_rvalid && fwd_rready;
    b_fire  <= fwd_bvalid && fwd_bready;
    ar_q <= fwd_ar;
    aw_q <= fwd_aw;
    w_q  <= fwd_w;
  end

  // the slave answers the handshakes of the last rising edge after random delays
  always @(negedge clk) begin
    if (ar_fire) begin
      rd_idx = ar_q.addr[5:2];
      rd_pending = 1'b1;
    end
    if (r_fire) fwd_rvalid = 1'b0;
    if (aw_fire) begin
      wr_idx = aw_q.addr[5:2];
      aw_seen = 1'b1;
    end
    if (w_fire) begin
      slave_mem[wr_idx] = merge_bytes(slave_mem[wr_idx], w_q.data, w_q.strb);
      w_seen = 1'b1;
    end
    if (b_fire) fwd_bvalid = 1'b0;
    if (rd_pending && !fwd_rvalid && ($urandom_range(0, 2) == 0)) begin
      fwd_r = '{data: slave_mem[rd_idx], resp: 2'b00};
      fwd_rvalid = 1'b1;
      rd_pending = 1'b0;
    end
    if (aw_seen && w_seen && !fwd_bvalid && ($urandom_range(0, 2) == 0)) begin
      fwd_b = '{resp: 2'b00};
      fwd_bvalid = 1'b1;
      aw_seen = 1'b0;
      w_seen = 1'b0;
    end
    fwd_arready = $urandom_range(0, 1);
    fwd_awready = $urandom_range(0, 1);
    fwd_wready = $urandom_range(0, 1);
    stream_tready = ($urandom_range(0, 3) != 0);
  end

  // stream sink compares every accepted word with the model queue
  always @(posedge clk) begin
    if (!resetn) begin
      held_valid = 1'b0;
    end else begin
      if (held_valid) begin
        check_value("stream valid hold", 1, stream_tvalid);
        check_value("stream word hold", held_word, stream_tdata);
      end
      held_valid = stream_tvalid && !stream_tready;
      held_word = stream_tdata;
      if (held_valid) begin
        assert (!((snoop_arvalid && snoop_arready) || (snoop_awvalid && snoop_awready) ||
                  (snoop_wvalid && snoop_wready) || (snoop_rvalid && snoop_rready) ||
                  (snoop_bvalid && snoop_bready)))
          else abort_run("an upstream handshake completed while the stream was stalled");
      end
      if (stream_tvalid && stream_tready) begin
        assert (exp_q.size() > 0) else abort_run("stream word arrived with none expected");
        sink_pkt = exp_q.pop_front();
        check_value("stream tdata", sink_pkt.word, stream_tdata);
        check_value("stream tstrb", sink_pkt.strb, stream_tstrb);
        check_value("stream tlast", sink_pkt.last, stream_tlast);
      end
    end
  end

  initial begin
    void'($urandom(53));
    clk = 1'b0;
    resetn = 1'b0;
    snoop_ar = '0;
    snoop_aw = '0;
    snoop_w = '0;
    {snoop_arvalid, snoop_awvalid, snoop_wvalid, snoop_rready, snoop_bready} = '0;
    {fwd_arready, fwd_awready, fwd_wready, fwd_rvalid, fwd_bvalid} = '0;
    fwd_r = '0;
    fwd_b = '0;
    stream_tready = 1'b0;
    {ar_fire, aw_fire, w_fire, r_fire, b_fire, rd_pending, aw_seen, w_seen} = '0;
    for (int i = 0; i < 16; i++) begin
      slave_mem[i] = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    // AW counts as the last grant, so a contested first grant goes to AR
    last_grant_ar = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    repeat (2) begin
      @(posedge clk);
      check_value("reset stream tvalid", 0, stream_tvalid);
      check_value("reset fwd valid", 0, {fwd_arvalid, fwd_awvalid, fwd_wvalid});
    end
    for (int k = 0; k < NUM_OPS; k++) begin
      op = $urandom_range(0, 4);
      idx = $urandom_range(0, 15);
      wdata = $urandom;
      wstrb = $urandom_range(1, 15);
      if (op == 0) begin
        // AR and AW arrive together and the loser of the last grant goes first
        if (last_grant_ar) begin
          push_exp(AW, 32'(idx * 4), wdata, wstrb);
          push_exp(W, 0, wdata, wstrb);
          push_exp(B, 0, 0, 0);
          model_mem[idx] = merge_bytes(model_mem[idx], wdata, wstrb);
          exp_rd = model_mem[idx];
          push_exp(AR, 32'(idx * 4), 0, 0);
          push_exp(R, 0, exp_rd, 0);
        end else begin
          exp_rd = model_mem[idx];
          push_exp(AR, 32'(idx * 4), 0, 0);
          push_exp(R, 0, exp_rd, 0);
          push_exp(AW, 32'(idx * 4), wdata, wstrb);
          push_exp(W, 0, wdata, wstrb);
          push_exp(B, 0, 0, 0);
          model_mem[idx] = merge_bytes(model_mem[idx], wdata, wstrb);
        end
        // serving the loser second leaves the last grant where it was
        fork
          run_read(idx, exp_rd);
          run_write(idx, wdata, wstrb);
        join
      end else if (op <= 2) begin
        push_exp(AR, 32'(idx * 4), 0, 0);
        push_exp(R, 0, model_mem[idx], 0);
        last_grant_ar = 1'b1;
        run_read(idx, model_mem[idx]);
      end else begin
        push_exp(AW, 32'(idx * 4), wdata, wstrb);
        push_exp(W, 0, wdata, wstrb);
        push_exp(B, 0, 0, 0);
        model_mem[idx] = merge_bytes(model_mem[idx], wdata, wstrb);
        last_grant_ar = 1'b0;
        run_write(idx, wdata, wstrb);
      end
    end
    // let the sink drain the last packets
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      assert (cycles < TIMEOUT_CYCLES) else abort_run("stream stopped with packets still expected");
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
